/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module csr_file_tb -f csr_file.f \
		--Mdir obj_dir -o csr_file_sim

run: compile
	./obj_dir/csr_file_sim | tee sim.log
	@if grep -q "Verification failed" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* csr_file.f */
hdl/csr_pkg.sv
hdl/exc_csr.sv
hdl/timer_csr.sv
hdl/scratch_csr.sv
hdl/csr_read_mux.sv
hdl/csr_file.sv
verif/csr_file_tb.sv

/* hdl/csr_file.sv */
`timescale 1ns/100ps

module csr_file #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         csr_we,
    input  logic [csr_pkg::NUM_W-1:0]    csr_wnum,
    input  logic [csr_pkg::DATA_W-1:0]   csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]   csr_wval,
    input  logic [csr_pkg::NUM_W-1:0]    csr_rnum,
    output logic [csr_pkg::DATA_W-1:0]   csr_rval,
    input  logic                         wb_exc,
    input  logic [csr_pkg::ECODE_W-1:0]  wb_ecode,
    input  logic [csr_pkg::ESUB_W-1:0]   wb_esubcode,
    input  logic [csr_pkg::DATA_W-1:0]   wb_pc,
    input  logic [csr_pkg::DATA_W-1:0]   wb_badvaddr,
    input  logic                         badv_is_pc,
    input  logic                         badv_is_mem,
    input  logic                         ertn_flush,
    output logic                         has_int,
    output logic [csr_pkg::DATA_W-1:0]   exc_entry,
    output logic [csr_pkg::DATA_W-1:0]   exc_retaddr
);

    logic [csr_pkg::PLV_W-1:0]        crmd_plv;
    logic                             crmd_ie;
    logic [csr_pkg::PLV_W-1:0]        prmd_pplv;
    logic                             prmd_pie;
    logic [csr_pkg::LIE_W-1:0]        ecfg_lie;
    logic [csr_pkg::LIE_W-1:0]        estat_is;
    logic [csr_pkg::ECODE_W-1:0]      estat_ecode;
    logic [csr_pkg::ESUB_W-1:0]       estat_esubcode;
    logic [csr_pkg::DATA_W-1:0]       era_pc;
    logic [csr_pkg::DATA_W-1:0]       badv_vaddr;
    logic [csr_pkg::EENTRY_VA_W-1:0]  eentry_va;
    logic                             tcfg_en;
    logic                             tcfg_period;
    logic [csr_pkg::TIMER_INIT_W-1:0] tcfg_initval;
    logic [csr_pkg::DATA_W-1:0]       timer_cnt;
    logic                             timer_int;
    logic [csr_pkg::DATA_W-1:0]       save_data [SAVE_COUNT];
    logic [csr_pkg::DATA_W-1:0]       tid;

    exc_csr u_exc (
        .clk            (clk),
        .rst            (rst),
        .csr_we         (csr_we),
        .csr_wnum       (csr_wnum),
        .csr_wmask      (csr_wmask),
        .csr_wval       (csr_wval),
        .wb_exc         (wb_exc),
        .wb_ecode       (wb_ecode),
        .wb_esubcode    (wb_esubcode),
        .wb_pc          (wb_pc),
        .wb_badvaddr    (wb_badvaddr),
        .badv_is_pc     (badv_is_pc),
        .badv_is_mem    (badv_is_mem),
        .ertn_flush     (ertn_flush),
        .timer_int      (timer_int),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is       (estat_is),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_va      (eentry_va),
        .has_int        (has_int),
        .exc_entry      (exc_entry),
        .exc_retaddr    (exc_retaddr)
    );

    timer_csr u_timer (
        .clk          (clk),
        .rst          (rst),
        .csr_we       (csr_we),
        .csr_wnum     (csr_wnum),
        .csr_wmask    (csr_wmask),
        .csr_wval     (csr_wval),
        .tcfg_en      (tcfg_en),
        .tcfg_period  (tcfg_period),
        .tcfg_initval (tcfg_initval),
        .timer_cnt    (timer_cnt),
        .timer_int    (timer_int)
    );

    scratch_csr #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_scratch (
        .clk       (clk),
        .rst       (rst),
        .csr_we    (csr_we),
        .csr_wnum  (csr_wnum),
        .csr_wmask (csr_wmask),
        .csr_wval  (csr_wval),
        .save_data (save_data),
        .tid       (tid)
    );

    csr_read_mux #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_rmux (
        .csr_rnum       (csr_rnum),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is       (estat_is),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_va      (eentry_va),
        .tcfg_en        (tcfg_en),
        .tcfg_period    (tcfg_period),
        .tcfg_initval   (tcfg_initval),
        .timer_cnt      (timer_cnt),
        .save_data      (save_data),
        .tid            (tid),
        .csr_rval       (csr_rval)
    );

endmodule

/* hdl/csr_pkg.sv */
package csr_pkg;

    localparam int DATA_W       = 32;
    localparam int NUM_W        = 14;
    localparam int PLV_W        = 2;
    // interrupt bits in ECFG.LIE and ESTAT.IS
    localparam int LIE_W        = 13;
    localparam int ECODE_W      = 6;
    localparam int ESUB_W       = 9;
    localparam int EENTRY_VA_W  = 26;
    localparam int TIMER_INIT_W = 30;

    // field positions
    localparam int IE_BIT        = 2;
    localparam int TIMER_INT_BIT = 11;
    localparam int TICLR_CLR_BIT = 0;

    // implemented csr numbers
    typedef enum logic [NUM_W-1:0] {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECFG   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        BADV   = 14'h007,
        EENTRY = 14'h00c,
        SAVE0  = 14'h030,
        SAVE1  = 14'h031,
        SAVE2  = 14'h032,
        SAVE3  = 14'h033,
        TID    = 14'h040,
        TCFG   = 14'h041,
        TVAL   = 14'h042,
        TICLR  = 14'h044
    } csr_num_e;

    // exception codes as recorded in ESTAT.Ecode
    typedef enum logic [ECODE_W-1:0] {
        INT = 6'h00,
        ADE = 6'h08,
        ALE = 6'h09,
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d
    } ecode_e;

    // new bits where mask is set, old bits elsewhere
    function automatic logic [DATA_W-1:0] mask_merge(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] mask,
        input logic [DATA_W-1:0] new_val
    );
        return (mask & new_val) | (~mask & old_val);
    endfunction

endpackage

/* hdl/csr_read_mux.sv */
`timescale 1ns/100ps

module csr_read_mux #(
    parameter int SAVE_COUNT = 4
) (
    input  logic [csr_pkg::NUM_W-1:0]        csr_rnum,
    input  logic [csr_pkg::PLV_W-1:0]        crmd_plv,
    input  logic                             crmd_ie,
    input  logic [csr_pkg::PLV_W-1:0]        prmd_pplv,
    input  logic                             prmd_pie,
    input  logic [csr_pkg::LIE_W-1:0]        ecfg_lie,
    input  logic [csr_pkg::LIE_W-1:0]        estat_is,
    input  logic [csr_pkg::ECODE_W-1:0]      estat_ecode,
    input  logic [csr_pkg::ESUB_W-1:0]       estat_esubcode,
    input  logic [csr_pkg::DATA_W-1:0]       era_pc,
    input  logic [csr_pkg::DATA_W-1:0]       badv_vaddr,
    input  logic [csr_pkg::EENTRY_VA_W-1:0]  eentry_va,
    input  logic                             tcfg_en,
    input  logic                             tcfg_period,
    input  logic [csr_pkg::TIMER_INIT_W-1:0] tcfg_initval,
    input  logic [csr_pkg::DATA_W-1:0]       timer_cnt,
    input  logic [csr_pkg::DATA_W-1:0]       save_data [SAVE_COUNT],
    input  logic [csr_pkg::DATA_W-1:0]       tid,
    output logic [csr_pkg::DATA_W-1:0]       csr_rval
);

    localparam int DW = csr_pkg::DATA_W;

    csr_pkg::csr_num_e rnum;
    logic [DW-1:0]     crmd_rval;
    logic [DW-1:0]     prmd_rval;
    logic [DW-1:0]     estat_rval;
    logic [DW-1:0]     eentry_rval;
    logic [DW-1:0]     tcfg_rval;

    assign rnum = csr_pkg::csr_num_e'(csr_rnum);

    // architectural layouts, reserved bits zero
    assign crmd_rval   = DW'({crmd_ie, crmd_plv});
    assign prmd_rval   = DW'({prmd_pie, prmd_pplv});
    assign estat_rval  = {1'b0, estat_esubcode, estat_ecode, 3'b000, estat_is};
    assign eentry_rval = {eentry_va, {(DW - csr_pkg::EENTRY_VA_W){1'b0}}};
    assign tcfg_rval   = {tcfg_initval, tcfg_period, tcfg_en};

    always_comb begin
        csr_rval = '0;
        case (rnum)
            csr_pkg::CRMD:   csr_rval = crmd_rval;
            csr_pkg::PRMD:   csr_rval = prmd_rval;
            csr_pkg::ECFG:   csr_rval = DW'(ecfg_lie);
            csr_pkg::ESTAT:  csr_rval = estat_rval;
            csr_pkg::ERA:    csr_rval = era_pc;
            csr_pkg::BADV:   csr_rval = badv_vaddr;
            csr_pkg::EENTRY: csr_rval = eentry_rval;
            csr_pkg::TID:    csr_rval = tid;
            csr_pkg::TCFG:   csr_rval = tcfg_rval;
            csr_pkg::TVAL:   csr_rval = timer_cnt;
            // TICLR is write-only
            csr_pkg::TICLR:  csr_rval = '0;
            default: begin
                // save block, sized by SAVE_COUNT
                for (int i = 0; i < SAVE_COUNT; i++) begin
                    if (csr_rnum == csr_pkg::NUM_W'(csr_pkg::SAVE0 + i)) begin
                        csr_rval = save_data[i];
                    end
                end
            end
        endcase
    end

endmodule

/* hdl/exc_csr.sv */
`timescale 1ns/100ps

module exc_csr (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             csr_we,
    input  logic [csr_pkg::NUM_W-1:0]        csr_wnum,
    input  logic [csr_pkg::DATA_W-1:0]       csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]       csr_wval,
    input  logic                             wb_exc,
    input  logic [csr_pkg::ECODE_W-1:0]      wb_ecode,
    input  logic [csr_pkg::ESUB_W-1:0]       wb_esubcode,
    input  logic [csr_pkg::DATA_W-1:0]       wb_pc,
    input  logic [csr_pkg::DATA_W-1:0]       wb_badvaddr,
    input  logic                             badv_is_pc,
    input  logic                             badv_is_mem,
    input  logic                             ertn_flush,
    input  logic                             timer_int,
    output logic [csr_pkg::PLV_W-1:0]        crmd_plv,
    output logic                             crmd_ie,
    output logic [csr_pkg::PLV_W-1:0]        prmd_pplv,
    output logic                             prmd_pie,
    output logic [csr_pkg::LIE_W-1:0]        ecfg_lie,
    output logic [csr_pkg::LIE_W-1:0]        estat_is,
    output logic [csr_pkg::ECODE_W-1:0]      estat_ecode,
    output logic [csr_pkg::ESUB_W-1:0]       estat_esubcode,
    output logic [csr_pkg::DATA_W-1:0]       era_pc,
    output logic [csr_pkg::DATA_W-1:0]       badv_vaddr,
    output logic [csr_pkg::EENTRY_VA_W-1:0]  eentry_va,
    output logic                             has_int,
    output logic [csr_pkg::DATA_W-1:0]       exc_entry,
    output logic [csr_pkg::DATA_W-1:0]       exc_retaddr
);

    localparam int DW = csr_pkg::DATA_W;

    logic          wr_crmd;
    logic          wr_prmd;
    logic          wr_ecfg;
    logic          wr_estat;
    logic          wr_era;
    logic          wr_eentry;
    logic [DW-1:0] crmd_new;
    logic [DW-1:0] prmd_new;
    logic [DW-1:0] ecfg_new;
    logic [DW-1:0] estat_new;
    logic [DW-1:0] era_new;
    logic [DW-1:0] eentry_new;
    // software interrupt bits, the only writable part of IS
    logic [1:0]    estat_swi;

    assign wr_crmd   = csr_we && csr_wnum == csr_pkg::CRMD;
    assign wr_prmd   = csr_we && csr_wnum == csr_pkg::PRMD;
    assign wr_ecfg   = csr_we && csr_wnum == csr_pkg::ECFG;
    assign wr_estat  = csr_we && csr_wnum == csr_pkg::ESTAT;
    assign wr_era    = csr_we && csr_wnum == csr_pkg::ERA;
    assign wr_eentry = csr_we && csr_wnum == csr_pkg::EENTRY;

    assign crmd_new   = csr_pkg::mask_merge(DW'({crmd_ie, crmd_plv}), csr_wmask, csr_wval);
    assign prmd_new   = csr_pkg::mask_merge(DW'({prmd_pie, prmd_pplv}), csr_wmask, csr_wval);
    assign ecfg_new   = csr_pkg::mask_merge(DW'(ecfg_lie), csr_wmask, csr_wval);
    assign estat_new  = csr_pkg::mask_merge(DW'(estat_swi), csr_wmask, csr_wval);
    assign era_new    = csr_pkg::mask_merge(era_pc, csr_wmask, csr_wval);
    assign eentry_new = csr_pkg::mask_merge(exc_entry, csr_wmask, csr_wval);

    // crmd: exception drops to plv0 with interrupts off, ertn restores
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_exc) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_new[csr_pkg::PLV_W-1:0];
            crmd_ie  <= crmd_new[csr_pkg::IE_BIT];
        end
    end

    // prmd, ecfg and estat software bits
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
            ecfg_lie  <= '0;
            estat_swi <= '0;
        end else begin
            if (wb_exc) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (wr_prmd) begin
                prmd_pplv <= prmd_new[csr_pkg::PLV_W-1:0];
                // PIE sits at the same position as IE
                prmd_pie  <= prmd_new[csr_pkg::IE_BIT];
            end
            if (wr_ecfg) begin
                ecfg_lie <= ecfg_new[csr_pkg::LIE_W-1:0];
            end
            if (wr_estat) begin
                estat_swi <= estat_new[1:0];
            end
        end
    end

    // exception record: codes, return pc, bad address
    always_ff @(posedge clk) begin
        if (rst) begin
            estat_ecode    <= csr_pkg::INT;
            estat_esubcode <= '0;
            era_pc         <= '0;
            badv_vaddr     <= '0;
        end else if (wb_exc) begin
            estat_ecode    <= csr_pkg::ecode_e'(wb_ecode);
            estat_esubcode <= wb_esubcode;
            era_pc         <= wb_pc;
            if (badv_is_pc) begin
                badv_vaddr <= wb_pc;
            end else if (badv_is_mem) begin
                badv_vaddr <= wb_badvaddr;
            end
        end else if (wr_era) begin
            era_pc <= era_new;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eentry_va <= '0;
        end else if (wr_eentry) begin
            eentry_va <= eentry_new[DW-1:DW-csr_pkg::EENTRY_VA_W];
        end
    end

    // hardware lines and ipi are not implemented
    always_comb begin
        estat_is                         = '0;
        estat_is[1:0]                    = estat_swi;
        estat_is[csr_pkg::TIMER_INT_BIT] = timer_int;
    end

    assign has_int     = crmd_ie & (|(estat_is & ecfg_lie));
    assign exc_entry   = {eentry_va, {(DW - csr_pkg::EENTRY_VA_W){1'b0}}};
    assign exc_retaddr = era_pc;

endmodule

/* hdl/scratch_csr.sv */
`timescale 1ns/100ps

module scratch_csr #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        csr_we,
    input  logic [csr_pkg::NUM_W-1:0]   csr_wnum,
    input  logic [csr_pkg::DATA_W-1:0]  csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]  csr_wval,
    output logic [csr_pkg::DATA_W-1:0]  save_data [SAVE_COUNT],
    output logic [csr_pkg::DATA_W-1:0]  tid
);

    // one word per SAVE number counting up from SAVE0
    for (genvar i = 0; i < SAVE_COUNT; i++) begin : g_save
        localparam logic [csr_pkg::NUM_W-1:0] SAVE_NUM = csr_pkg::NUM_W'(csr_pkg::SAVE0 + i);

        always_ff @(posedge clk) begin
            if (rst) begin
                save_data[i] <= '0;
            end else if (csr_we && csr_wnum == SAVE_NUM) begin
                save_data[i] <= csr_pkg::mask_merge(save_data[i], csr_wmask, csr_wval);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tid <= '0;
        end else if (csr_we && csr_wnum == csr_pkg::TID) begin
            tid <= csr_pkg::mask_merge(tid, csr_wmask, csr_wval);
        end
    end

endmodule

/* hdl/timer_csr.sv */
`timescale 1ns/100ps

module timer_csr (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              csr_we,
    input  logic [csr_pkg::NUM_W-1:0]         csr_wnum,
    input  logic [csr_pkg::DATA_W-1:0]        csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]        csr_wval,
    output logic                              tcfg_en,
    output logic                              tcfg_period,
    output logic [csr_pkg::TIMER_INIT_W-1:0]  tcfg_initval,
    output logic [csr_pkg::DATA_W-1:0]        timer_cnt,
    output logic                              timer_int
);

    localparam int DW = csr_pkg::DATA_W;

    logic          wr_tcfg;
    logic          clr_req;
    logic [DW-1:0] tcfg_next;

    assign wr_tcfg   = csr_we && csr_wnum == csr_pkg::TCFG;
    assign clr_req   = csr_we && csr_wnum == csr_pkg::TICLR &&
                       csr_wmask[csr_pkg::TICLR_CLR_BIT] && csr_wval[csr_pkg::TICLR_CLR_BIT];
    // tcfg as it will be after this cycle's write
    assign tcfg_next = csr_pkg::mask_merge({tcfg_initval, tcfg_period, tcfg_en},
                                           csr_wmask, csr_wval);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_en      <= 1'b0;
            tcfg_period  <= 1'b0;
            tcfg_initval <= '0;
        end else if (wr_tcfg) begin
            tcfg_en      <= tcfg_next[0];
            tcfg_period  <= tcfg_next[1];
            tcfg_initval <= tcfg_next[DW-1:2];
        end
    end

    // countdown that parks at all ones when a one-shot expires
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_cnt <= '1;
        end else if (wr_tcfg && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[DW-1:2], 2'b00};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_period) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - DW'(1);
            end
        end
    end

    // set beats clear
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (clr_req) begin
            timer_int <= 1'b0;
        end
    end

endmodule

/* verif/csr_file_tb.sv */
`timescale 1ns/100ps

module csr_file_tb;

    localparam int SAVE_COUNT = 4;
    // the tests use about 2000 cycles
    localparam int MAX_CYCLES = 5000;

    logic        clk;
    logic        rst;
    logic        csr_we;
    logic [13:0] csr_wnum;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wval;
    logic [13:0] csr_rnum;
    logic [31:0] csr_rval;
    logic        wb_exc;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_badvaddr;
    logic        badv_is_pc;
    logic        badv_is_mem;
    logic        ertn_flush;
    logic        has_int;
    logic [31:0] exc_entry;
    logic [31:0] exc_retaddr;

    // reference model state
    logic [1:0]  m_plv;
    logic        m_ie;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic [12:0] m_lie;
    logic [1:0]  m_swi;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [25:0] m_eentry;
    logic [31:0] m_save [SAVE_COUNT];
    logic [31:0] m_tid;
    logic        m_en;
    logic        m_period;
    logic [29:0] m_initval;
    logic [31:0] m_cnt;
    logic        m_tint;

    logic [31:0] lfsr;
    int          cycles = 0;

    logic [13:0] wr_targets [9] = '{csr_pkg::PRMD, csr_pkg::ECFG, csr_pkg::ERA,
                                   csr_pkg::EENTRY, csr_pkg::SAVE0, csr_pkg::SAVE1,
                                   csr_pkg::SAVE2, csr_pkg::SAVE3, csr_pkg::TID};
    logic [5:0]  ecodes [6] = '{csr_pkg::INT, csr_pkg::ADE, csr_pkg::ALE,
                               csr_pkg::SYS, csr_pkg::BRK, csr_pkg::INE};

    csr_file #(
        .SAVE_COUNT (SAVE_COUNT)
    ) DUT (.*);

    always #10 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bits(input logic [31:0] old_v,
                                               input logic [31:0] mask,
                                               input logic [31:0] new_v);
        logic [31:0] r;
        int          i;
        for (i = 0; i < 32; i++) begin
            r[i] = mask[i] ? new_v[i] : old_v[i];
        end
        return r;
    endfunction

    // swi in 1:0 and timer in 11
    function automatic logic [12:0] model_is();
        logic [12:0] r;
        r = '0;
        r[1:0] = m_swi;
        r[11] = m_tint;
        return r;
    endfunction

    function automatic logic [31:0] expected_rval(input logic [13:0] num);
        logic [31:0] r;
        case (num)
            csr_pkg::CRMD:   r = {29'b0, m_ie, m_plv};
            csr_pkg::PRMD:   r = {29'b0, m_pie, m_pplv};
            csr_pkg::ECFG:   r = {19'b0, m_lie};
            csr_pkg::ESTAT:  r = {1'b0, m_esub, m_ecode, 3'b000, model_is()};
            csr_pkg::ERA:    r = m_era;
            csr_pkg::BADV:   r = m_badv;
            csr_pkg::EENTRY: r = {m_eentry, 6'b0};
            csr_pkg::SAVE0:  r = m_save[0];
            csr_pkg::SAVE1:  r = m_save[1];
            csr_pkg::SAVE2:  r = m_save[2];
            csr_pkg::SAVE3:  r = m_save[3];
            csr_pkg::TID:    r = m_tid;
            csr_pkg::TCFG:   r = {m_initval, m_period, m_en};
            csr_pkg::TVAL:   r = m_cnt;
            default:         r = '0;
        endcase
        return r;
    endfunction

    task automatic reset_model();
        int i;
        {m_plv, m_ie, m_pplv, m_pie, m_lie, m_swi, m_ecode, m_esub} = '0;
        {m_era, m_badv, m_eentry, m_tid, m_en, m_period, m_initval, m_tint} = '0;
        for (i = 0; i < SAVE_COUNT; i++) begin
            m_save[i] = '0;
        end
        m_cnt = '1;
    endtask

    // one clock edge of the model with inputs as sampled at the edge
    task automatic step_model();
        logic [31:0] w;
        logic [31:0] t_new;
        logic        wr_tcfg;
        logic        clr;
        t_new   = merge_bits({m_initval, m_period, m_en}, csr_wmask, csr_wval);
        wr_tcfg = csr_we && csr_wnum == csr_pkg::TCFG;
        clr     = csr_we && csr_wnum == csr_pkg::TICLR && csr_wmask[0] && csr_wval[0];
        if (wb_exc) begin
            m_pplv  = m_plv;
            m_pie   = m_ie;
            m_plv   = '0;
            m_ie    = 1'b0;
            m_ecode = wb_ecode;
            m_esub  = wb_esubcode;
            m_era   = wb_pc;
            if (badv_is_pc) begin
                m_badv = wb_pc;
            end else if (badv_is_mem) begin
                m_badv = wb_badvaddr;
            end
        end else begin
            if (ertn_flush) begin
                m_plv = m_pplv;
                m_ie  = m_pie;
            end else if (csr_we && csr_wnum == csr_pkg::CRMD) begin
                w = merge_bits({29'b0, m_ie, m_plv}, csr_wmask, csr_wval);
                m_plv = w[1:0];
                m_ie  = w[2];
            end
            if (csr_we && csr_wnum == csr_pkg::PRMD) begin
                w = merge_bits({29'b0, m_pie, m_pplv}, csr_wmask, csr_wval);
                m_pplv = w[1:0];
                m_pie  = w[2];
            end
            if (csr_we && csr_wnum == csr_pkg::ERA) begin
                m_era = merge_bits(m_era, csr_wmask, csr_wval);
            end
        end
        if (csr_we) begin
            case (csr_wnum)
                csr_pkg::ECFG:   m_lie = 13'(merge_bits({19'b0, m_lie}, csr_wmask, csr_wval));
                csr_pkg::ESTAT:  m_swi = 2'(merge_bits({30'b0, m_swi}, csr_wmask, csr_wval));
                csr_pkg::EENTRY: begin
                    w = merge_bits({m_eentry, 6'b0}, csr_wmask, csr_wval);
                    m_eentry = w[31:6];
                end
                csr_pkg::SAVE0:  m_save[0] = merge_bits(m_save[0], csr_wmask, csr_wval);
                csr_pkg::SAVE1:  m_save[1] = merge_bits(m_save[1], csr_wmask, csr_wval);
                csr_pkg::SAVE2:  m_save[2] = merge_bits(m_save[2], csr_wmask, csr_wval);
                csr_pkg::SAVE3:  m_save[3] = merge_bits(m_save[3], csr_wmask, csr_wval);
                csr_pkg::TID:    m_tid = merge_bits(m_tid, csr_wmask, csr_wval);
                default: ;
            endcase
        end
        // pending bit looks at the count before this edge
        if (m_cnt == '0) begin
            m_tint = 1'b1;
        end else if (clr) begin
            m_tint = 1'b0;
        end
        if (wr_tcfg && t_new[0]) begin
            m_cnt = {t_new[31:2], 2'b00};
        end else if (m_en && m_cnt != '1) begin
            if (m_cnt == '0 && m_period) begin
                m_cnt = {m_initval, 2'b00};
            end else begin
                m_cnt = m_cnt - 32'd1;
            end
        end
        if (wr_tcfg) begin
            {m_initval, m_period, m_en} = t_new;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            check_value("csr_rval", expected_rval(csr_rnum), csr_rval);
            check_value("has_int", {31'b0, m_ie & (|(model_is() & m_lie))}, {31'b0, has_int});
            check_value("exc_entry", {m_eentry, 6'b0}, exc_entry);
            check_value("exc_retaddr", m_era, exc_retaddr);
            step_model();
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish");
            $display("Verification failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // stimulus tasks start and end on a falling edge
    task automatic csr_write(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] val);
        csr_we    = 1'b1;
        csr_wnum  = num;
        csr_wmask = mask;
        csr_wval  = val;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    task automatic csr_read(input logic [13:0] num);
        csr_rnum = num;
        @(negedge clk);
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] esub,
                                   input logic [31:0] pc, input logic [31:0] vaddr,
                                   input logic [1:0] flags);
        wb_exc      = 1'b1;
        wb_ecode    = ecode;
        wb_esubcode = esub;
        wb_pc       = pc;
        wb_badvaddr = vaddr;
        badv_is_pc  = flags[1];
        badv_is_mem = flags[0];
        @(negedge clk);
        wb_exc = 1'b0;
    endtask

    task automatic return_from_exception();
        ertn_flush = 1'b1;
        @(negedge clk);
        ertn_flush = 1'b0;
    endtask

    initial begin
        int          i;
        int          idx;
        logic [13:0] num;
        logic [31:0] mask;
        logic [31:0] v;
        logic [31:0] pc;
        clk = 1'b0;
        rst = 1'b1;
        {csr_we, csr_wnum, csr_wmask, csr_wval, csr_rnum} = '0;
        {wb_exc, wb_ecode, wb_esubcode, wb_pc, wb_badvaddr} = '0;
        {badv_is_pc, badv_is_mem, ertn_flush} = '0;
        lfsr = 32'd27;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // random masked writes with readback
        for (i = 0; i < 600; i++) begin
            idx  = int'(take_bits(4) % 32'd9);
            num  = wr_targets[idx];
            mask = take_bits(32);
            v    = take_bits(32);
            csr_write(num, mask, v);
            csr_read(num);
        end
        csr_read(14'h010);

        // exception entry then return
        for (i = 0; i < 48; i++) begin
            csr_write(csr_pkg::CRMD, 32'hffff_ffff, take_bits(3));
            idx  = int'(take_bits(3) % 32'd6);
            pc   = take_bits(32);
            v    = take_bits(32);
            mask = take_bits(9);
            raise_exception(ecodes[idx], mask[8:0], pc, v, 2'(take_bits(2)));
            csr_read(csr_pkg::CRMD);
            csr_read(csr_pkg::PRMD);
            csr_read(csr_pkg::ERA);
            csr_read(csr_pkg::ESTAT);
            csr_read(csr_pkg::BADV);
            csr_read(csr_pkg::EENTRY);
            csr_write(csr_pkg::PRMD, 32'h7, take_bits(3));
            return_from_exception();
            csr_read(csr_pkg::CRMD);
            csr_read(csr_pkg::ERA);
        end

        // one-shot timer from 20
        csr_write(csr_pkg::TCFG, 32'hffff_ffff, {30'd5, 1'b0, 1'b1});
        for (i = 0; i < 30; i++) begin
            csr_read(csr_pkg::TVAL);
        end
        csr_read(csr_pkg::ESTAT);
        repeat (5) csr_read(csr_pkg::TVAL);
        csr_write(csr_pkg::TICLR, 32'h1, 32'h1);
        csr_read(csr_pkg::ESTAT);

        // periodic timer raising has_int through LIE bit 11
        csr_write(csr_pkg::ECFG, 32'h0000_1fff, 32'h0000_0800);
        csr_write(csr_pkg::CRMD, 32'h4, 32'h4);
        csr_write(csr_pkg::TCFG, 32'hffff_ffff, {30'd3, 1'b1, 1'b1});
        for (i = 0; i < 40; i++) begin
            csr_read(csr_pkg::TVAL);
        end
        while (!m_tint) begin
            csr_read(csr_pkg::TVAL);
        end
        csr_write(csr_pkg::TICLR, 32'h1, 32'h1);
        csr_read(csr_pkg::ESTAT);
        csr_read(csr_pkg::ESTAT);
        csr_write(csr_pkg::TCFG, 32'h1, 32'h0);
        csr_write(csr_pkg::TICLR, 32'h1, 32'h1);
        csr_read(csr_pkg::ESTAT);
        csr_read(csr_pkg::TCFG);
        csr_read(csr_pkg::TICLR);

        // software interrupt bits
        csr_write(csr_pkg::ECFG, 32'h0000_1fff, 32'h0000_0003);
        csr_write(csr_pkg::CRMD, 32'h4, 32'h4);
        csr_write(csr_pkg::ESTAT, 32'hffff_ffff, 32'hffff_ffff);
        csr_read(csr_pkg::ESTAT);
        csr_write(csr_pkg::CRMD, 32'h4, 32'h0);
        csr_read(csr_pkg::ESTAT);
        csr_write(csr_pkg::ESTAT, 32'h3, 32'h0);
        csr_read(csr_pkg::ESTAT);

        repeat (2) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule
